//--- common/isaPkg.sv
package isaPkg;

  //////////////////////////////////////////////////
  // Word and field types
  //////////////////////////////////////////////////

  typedef logic [31:0] word_t;
  typedef logic [4:0]  regAddr_t;
  typedef logic [5:0]  opcode_t;
  typedef logic [5:0]  funct_t;

  // Low bit of each instruction field
  localparam int OP_LSB = 26;
  localparam int RS_LSB = 21;
  localparam int RT_LSB = 16;
  localparam int RD_LSB = 11;
  localparam int FN_LSB = 0;
  // Immediate and jump index widths
  localparam int IMM_W    = 16;
  localparam int TARGET_W = 26;

  //////////////////////////////////////////////////
  // Primary opcodes
  //////////////////////////////////////////////////

  localparam opcode_t OP_RTYPE = 6'h00;
  localparam opcode_t OP_J     = 6'h02;
  localparam opcode_t OP_JAL   = 6'h03;
  localparam opcode_t OP_BEQ   = 6'h04;
  localparam opcode_t OP_BNE   = 6'h05;
  localparam opcode_t OP_ADDI  = 6'h08;
  localparam opcode_t OP_ANDI  = 6'h0c;
  localparam opcode_t OP_ORI   = 6'h0d;
  localparam opcode_t OP_LB    = 6'h20;
  localparam opcode_t OP_LH    = 6'h21;
  localparam opcode_t OP_LW    = 6'h23;
  localparam opcode_t OP_SB    = 6'h28;
  localparam opcode_t OP_SH    = 6'h29;
  localparam opcode_t OP_SW    = 6'h2b;

  // R-type function codes
  localparam funct_t FN_SLL = 6'h00;
  localparam funct_t FN_JR  = 6'h08;
  localparam funct_t FN_ADD = 6'h20;
  localparam funct_t FN_SUB = 6'h22;
  localparam funct_t FN_AND = 6'h24;
  localparam funct_t FN_OR  = 6'h25;
  localparam funct_t FN_SLT = 6'h2a;

  // Named registers
  localparam regAddr_t REG_ZERO = 5'd0;
  localparam regAddr_t REG_V0   = 5'd2;
  localparam regAddr_t REG_V1   = 5'd3;
  localparam regAddr_t REG_RA   = 5'd31;

endpackage

//--- common/controlPkg.sv
package controlPkg;

  //////////////////////////////////////////////////
  // Second ALU operand select
  //////////////////////////////////////////////////

  typedef logic [1:0] aluSrc1_t;

  // Register operand
  localparam aluSrc1_t ALU1_REG     = 2'd0;
  // Sign-extended immediate
  localparam aluSrc1_t ALU1_SIGNIMM = 2'd1;
  // Zero-extended immediate, andi/ori
  localparam aluSrc1_t ALU1_ZEROIMM = 2'd2;

  //////////////////////////////////////////////////
  // Memory access width
  //////////////////////////////////////////////////

  typedef logic [1:0] memWidth_t;

  localparam memWidth_t WIDTH_WORD = 2'd0;
  localparam memWidth_t WIDTH_HALF = 2'd1;
  localparam memWidth_t WIDTH_BYTE = 2'd2;

  //////////////////////////////////////////////////
  // Immediate extension
  //////////////////////////////////////////////////

  typedef logic extendSel_t;

  // Copy bit 15 into the upper half
  localparam extendSel_t EXT_SIGN = 1'b0;
  // Upper half cleared
  localparam extendSel_t EXT_ZERO = 1'b1;

endpackage

//--- common/regReadIf.sv
`timescale 1ns/1ps

interface regReadIf
  import isaPkg::*;
  ();

  // Read addresses from the decoder
  regAddr_t rsAddr;
  regAddr_t rtAddr;
  // Combinational read data from the register file
  word_t    rsData;
  word_t    rtData;

  // Decoder side
  modport requester (
    output rsAddr,
    output rtAddr
  );

  // Register file side
  modport responder (
    input  rsAddr,
    input  rtAddr,
    output rsData,
    output rtData
  );

  // Consumers of the operands
  modport monitor (
    input rsData,
    input rtData
  );

endinterface

//--- instructionDecode/decodeController.sv
`timescale 1ns/1ps

module decodeController
  import isaPkg::*;
  import controlPkg::*;
(
  input  word_t        instruction,
  regReadIf.requester  rd,
  output logic         regDst,
  output logic         aluSrc0,
  output logic         rEnable,
  output logic         wEnable,
  output logic         memToReg,
  output logic         regWriteOut,
  output logic         jal,
  output aluSrc1_t     aluSrc1,
  output memWidth_t    rWidth,
  output memWidth_t    wWidth,
  output extendSel_t   extendSel
);

  opcode_t opcode;
  funct_t  funct;
  // Instruction uses rt as a source
  logic    readsRt;
  logic    isJr;

  assign opcode = instruction[OP_LSB +: 6];
  assign funct  = instruction[FN_LSB +: 6];

  //////////////////////////////////////////////////
  // Main decoder
  //////////////////////////////////////////////////

  always_comb begin
    // Safe defaults, no write and no memory access
    regDst      = 1'b0;
    aluSrc0     = 1'b0;
    aluSrc1     = ALU1_REG;
    rEnable     = 1'b0;
    wEnable     = 1'b0;
    rWidth      = WIDTH_WORD;
    wWidth      = WIDTH_WORD;
    memToReg    = 1'b0;
    regWriteOut = 1'b0;
    jal         = 1'b0;
    extendSel   = EXT_SIGN;
    readsRt     = 1'b0;
    isJr        = 1'b0;
    case (opcode)
      OP_RTYPE: begin
        case (funct)
          FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT: begin
            regDst      = 1'b1;
            regWriteOut = 1'b1;
            readsRt     = 1'b1;
          end
          FN_SLL: begin
            // Shift amount comes from the shamt field
            regDst      = 1'b1;
            aluSrc0     = 1'b1;
            regWriteOut = 1'b1;
            readsRt     = 1'b1;
          end
          FN_JR: isJr = 1'b1;
          default: ;
        endcase
      end
      OP_ADDI: begin
        aluSrc1     = ALU1_SIGNIMM;
        regWriteOut = 1'b1;
      end
      OP_ANDI, OP_ORI: begin
        // Logical immediates are zero extended
        aluSrc1     = ALU1_ZEROIMM;
        extendSel   = EXT_ZERO;
        regWriteOut = 1'b1;
      end
      OP_LW, OP_LH, OP_LB: begin
        aluSrc1     = ALU1_SIGNIMM;
        rEnable     = 1'b1;
        memToReg    = 1'b1;
        regWriteOut = 1'b1;
        rWidth      = (opcode == OP_LW) ? WIDTH_WORD :
                      (opcode == OP_LH) ? WIDTH_HALF : WIDTH_BYTE;
      end
      OP_SW, OP_SH, OP_SB: begin
        // Store data travels on rt
        aluSrc1 = ALU1_SIGNIMM;
        wEnable = 1'b1;
        readsRt = 1'b1;
        wWidth  = (opcode == OP_SW) ? WIDTH_WORD :
                  (opcode == OP_SH) ? WIDTH_HALF : WIDTH_BYTE;
      end
      OP_BEQ, OP_BNE: readsRt = 1'b1;
      // Link write happens inside the register file
      OP_JAL: jal = 1'b1;
      default: ;
    endcase
  end

  // Read port selects
  // jr always returns through ra
  assign rd.rsAddr = isJr ? REG_RA : instruction[RS_LSB +: 5];
  assign rd.rtAddr = readsRt ? instruction[RT_LSB +: 5] : REG_ZERO;

endmodule

//--- instructionDecode/registerFile.sv
`timescale 1ns/1ps

module registerFile
  import isaPkg::*;
(
  input  logic         Clock,
  input  logic         rst,
  input  logic         jal,
  regReadIf.responder  rd,
  input  regAddr_t     rDestSelectedId,
  input  word_t        regWriteData,
  input  word_t        pcPlusFour,
  input  logic         regWrite,
  output word_t        v0,
  output word_t        v1
);

  word_t regs [32];

  //////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////

  always_ff @(posedge Clock) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else begin
      // Write-back from the last stage, r0 never written
      if (regWrite && (rDestSelectedId != REG_ZERO)) begin
        regs[rDestSelectedId] <= regWriteData;
      end
      // Link write comes last so it wins on ra
      if (jal) begin
        regs[REG_RA] <= pcPlusFour;
      end
    end
  end

  //////////////////////////////////////////////////
  // Read ports
  //////////////////////////////////////////////////

  // Combinational, old value during a write
  // r0 forced to zero on both ports
  assign rd.rsData = (rd.rsAddr == REG_ZERO) ? '0 : regs[rd.rsAddr];
  assign rd.rtData = (rd.rtAddr == REG_ZERO) ? '0 : regs[rd.rtAddr];

  // Result registers brought out for observation
  assign v0 = regs[REG_V0];
  assign v1 = regs[REG_V1];

endmodule

//--- instructionDecode/immediateBranchUnit.sv
`timescale 1ns/1ps

module immediateBranchUnit
  import isaPkg::*;
  import controlPkg::*;
(
  input  word_t       instruction,
  input  word_t       pcPlusFour,
  input  extendSel_t  extendSel,
  regReadIf.monitor   rd,
  input  logic        stallPc,
  output word_t       imm32,
  output word_t       branchPc,
  output logic        pcSel
);

  opcode_t opcode;
  funct_t  funct;
  word_t   signImm;
  word_t   branchTarget;
  word_t   jumpTarget;
  logic    isJump;
  logic    isJr;
  logic    operandsEqual;
  logic    taken;

  assign opcode = instruction[OP_LSB +: 6];
  assign funct  = instruction[FN_LSB +: 6];

  //////////////////////////////////////////////////
  // Immediate extension
  //////////////////////////////////////////////////

  assign signImm = {{(32 - IMM_W){instruction[IMM_W - 1]}}, instruction[IMM_W - 1:0]};
  assign imm32   = (extendSel == EXT_ZERO) ? {{(32 - IMM_W){1'b0}}, instruction[IMM_W - 1:0]}
                                           : signImm;

  // Branch offset is always signed, word aligned
  assign branchTarget = pcPlusFour + (signImm << 2);
  // Region bits from PC+4, index in words
  assign jumpTarget   = {pcPlusFour[31:TARGET_W + 2], instruction[TARGET_W - 1:0], 2'b00};

  //////////////////////////////////////////////////
  // Redirect decision
  //////////////////////////////////////////////////

  assign isJump        = (opcode == OP_J) || (opcode == OP_JAL);
  assign isJr          = (opcode == OP_RTYPE) && (funct == FN_JR);
  assign operandsEqual = (rd.rsData == rd.rtData);

  always_comb begin
    case (opcode)
      OP_BEQ:  taken = operandsEqual;
      OP_BNE:  taken = !operandsEqual;
      default: taken = isJump || isJr;
    endcase
  end

  // jr target is ra, selected as rs by the decoder
  assign branchPc = isJump ? jumpTarget :
                    isJr   ? rd.rsData  : branchTarget;

  // A stalled branch must not redirect fetch
  assign pcSel = taken && !stallPc;

endmodule

//--- instructionDecode/hazardDetector.sv
`timescale 1ns/1ps

module hazardDetector
  import isaPkg::*;
(
  input  word_t     instruction,
  input  regAddr_t  rtEx,
  input  regAddr_t  rdEx,
  input  regAddr_t  rDestSelectedMem,
  input  opcode_t   opcodeEx,
  input  opcode_t   opcodeMem,
  output logic      stallPc,
  output logic      stallId,
  output logic      bubbleIdEx
);

  opcode_t  opcode;
  funct_t   funct;
  regAddr_t srcRs;
  regAddr_t srcRt;
  regAddr_t destEx;
  logic     isJr;
  logic     isBranch;
  logic     readsRt;
  logic     loadEx;
  logic     loadMem;
  logic     loadUse;
  logic     branchOperand;

  // Source collides with EX result or MEM load result
  function automatic logic pendingWrite(regAddr_t src);
    return (src != REG_ZERO) &&
           ((src == destEx) || (loadMem && (src == rDestSelectedMem)));
  endfunction

  assign opcode = instruction[OP_LSB +: 6];
  assign funct  = instruction[FN_LSB +: 6];
  assign isJr   = (opcode == OP_RTYPE) && (funct == FN_JR);
  // Same source selection as the decoder, jr reads ra
  assign srcRs  = isJr ? REG_RA : instruction[RS_LSB +: 5];
  assign srcRt  = instruction[RT_LSB +: 5];

  // rt is a source for R-type ALU ops, stores and branches
  assign readsRt = ((opcode == OP_RTYPE) &&
                    (funct inside {FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT, FN_SLL})) ||
                   (opcode == OP_SW) || (opcode == OP_SH) || (opcode == OP_SB) ||
                   (opcode == OP_BEQ) || (opcode == OP_BNE);
  assign isBranch = (opcode == OP_BEQ) || (opcode == OP_BNE) || isJr;

  assign loadEx  = (opcodeEx == OP_LW) || (opcodeEx == OP_LH) || (opcodeEx == OP_LB);
  assign loadMem = (opcodeMem == OP_LW) || (opcodeMem == OP_LH) || (opcodeMem == OP_LB);
  // EX destination field depends on format
  assign destEx  = (opcodeEx == OP_RTYPE) ? rdEx : rtEx;

  //////////////////////////////////////////////////
  // Hazard terms
  //////////////////////////////////////////////////

  // Load result not ready for the next instruction
  assign loadUse = loadEx && (rtEx != REG_ZERO) &&
                   ((rtEx == srcRs) || (readsRt && (rtEx == srcRt)));

  // Branch compares in ID, needs final operands now
  assign branchOperand = isBranch &&
                         (pendingWrite(srcRs) || (readsRt && pendingWrite(srcRt)));

  // Hold PC and ID, insert a bubble into EX
  assign stallPc    = loadUse || branchOperand;
  assign stallId    = stallPc;
  assign bubbleIdEx = stallPc;

endmodule

//--- instructionDecode/instructionDecode.sv
`timescale 1ns/1ps

module instructionDecode
  import isaPkg::*;
  import controlPkg::*;
(
  input  logic        Clock,
  input  logic        rst,
  // Standard ID stage
  input  word_t       instruction,
  input  word_t       pcPlusFour,
  input  regAddr_t    rDestSelectedId,
  input  word_t       regWriteData,
  input  logic        regWrite,
  // Hazard inputs from EX and MEM
  input  regAddr_t    rtEx,
  input  regAddr_t    rdEx,
  input  regAddr_t    rDestSelectedMem,
  input  opcode_t     opcodeEx,
  input  opcode_t     opcodeMem,
  // Fetch redirect
  output logic        pcSel,
  output word_t       branchPc,
  // MEM/WB controls
  output logic        regWriteOut,
  output logic        memToReg,
  // EX/MEM controls
  output logic        rEnable,
  output logic        wEnable,
  output memWidth_t   rWidth,
  output memWidth_t   wWidth,
  // ID/EX controls
  output logic        regDst,
  output logic        aluSrc0,
  output aluSrc1_t    aluSrc1,
  // Operands
  output word_t       regData1,
  output word_t       regData2,
  output word_t       imm32,
  // Hazard outputs
  output logic        stallPc,
  output logic        stallId,
  output logic        bubbleIdEx,
  output word_t       v0,
  output word_t       v1
);

  logic       jal;
  extendSel_t extendSel;

  regReadIf rdBus ();

  //////////////////////////////////////////////////
  // Decode blocks
  //////////////////////////////////////////////////

  decodeController decodeCtrl (
    .instruction (instruction),
    .rd          (rdBus.requester),
    .regDst      (regDst),
    .aluSrc0     (aluSrc0),
    .rEnable     (rEnable),
    .wEnable     (wEnable),
    .memToReg    (memToReg),
    .regWriteOut (regWriteOut),
    .jal         (jal),
    .aluSrc1     (aluSrc1),
    .rWidth      (rWidth),
    .wWidth      (wWidth),
    .extendSel   (extendSel)
  );

  registerFile regFile (
    .Clock           (Clock),
    .rst             (rst),
    .jal             (jal),
    .rd              (rdBus.responder),
    .rDestSelectedId (rDestSelectedId),
    .regWriteData    (regWriteData),
    .pcPlusFour      (pcPlusFour),
    .regWrite        (regWrite),
    .v0              (v0),
    .v1              (v1)
  );

  immediateBranchUnit immBranch (
    .instruction (instruction),
    .pcPlusFour  (pcPlusFour),
    .extendSel   (extendSel),
    .rd          (rdBus.monitor),
    .stallPc     (stallPc),
    .imm32       (imm32),
    .branchPc    (branchPc),
    .pcSel       (pcSel)
  );

  hazardDetector hazard (
    .instruction      (instruction),
    .rtEx             (rtEx),
    .rdEx             (rdEx),
    .rDestSelectedMem (rDestSelectedMem),
    .opcodeEx         (opcodeEx),
    .opcodeMem        (opcodeMem),
    .stallPc          (stallPc),
    .stallId          (stallId),
    .bubbleIdEx       (bubbleIdEx)
  );

  // Operands straight from the read ports
  assign regData1 = rdBus.rsData;
  assign regData2 = rdBus.rtData;

endmodule

//--- verification/instructionDecodeTb.sv
`timescale 1ns/1ps

module instructionDecodeTb
  import isaPkg::*;
  import controlPkg::*;
();

  localparam int  NUM_CYCLES = 2000;
  localparam time CLK_PERIOD = 8;
  localparam time RESET_TIME = 2 * CLK_PERIOD;

  // DUT inputs
  logic     Clock = 1'b0;
  logic     rst;
  word_t    instruction;
  word_t    pcPlusFour;
  regAddr_t rDestSelectedId;
  word_t    regWriteData;
  logic     regWrite;
  regAddr_t rtEx;
  regAddr_t rdEx;
  regAddr_t rDestSelectedMem;
  opcode_t  opcodeEx;
  opcode_t  opcodeMem;
  // DUT outputs
  logic      pcSel, regWriteOut, memToReg, rEnable, wEnable, regDst, aluSrc0;
  logic      stallPc, stallId, bubbleIdEx;
  memWidth_t rWidth, wWidth;
  aluSrc1_t  aluSrc1;
  word_t     branchPc, regData1, regData2, imm32, v0, v1;

  // Reference copy of the register file
  word_t model [32];
  int    cycle;

  instructionDecode uut (.*);

  always #(CLK_PERIOD / 2) Clock = !Clock;

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic checkWord(string name, word_t expected, word_t actual);
    if (expected !== actual) begin
      $display("ERR %s cycle %0d expected %h actual %h", name, cycle, expected, actual);
      $display("Test failed");
      $fatal(1, "Word mismatch");
    end
  endtask

  task automatic checkCtrl(string name, logic [13:0] expected, logic [13:0] actual);
    if (expected !== actual) begin
      $display("ERR %s cycle %0d expected %h actual %h", name, cycle, expected, actual);
      $display("Test failed");
      $fatal(1, "Control mismatch");
    end
  endtask

  task automatic checkStall(string name, logic expected, logic actual);
    if (expected !== actual) begin
      $display("ERR %s cycle %0d expected %b actual %b", name, cycle, expected, actual);
      $display("Test failed");
      $fatal(1, "Hazard signal mismatch");
    end
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic memWidth_t widthOf(opcode_t op);
    case (op)
      OP_LW, OP_SW: return WIDTH_WORD;
      OP_LH, OP_SH: return WIDTH_HALF;
      default:      return WIDTH_BYTE;
    endcase
  endfunction

  // Nonzero source written by EX, or loaded by MEM
  function automatic logic pendingAt(regAddr_t src, regAddr_t destEx, logic loadMem);
    return (src != 5'd0) && ((src == destEx) || (loadMem && (src == rDestSelectedMem)));
  endfunction

  task automatic checkOutputs();
    opcode_t     op;
    funct_t      fn;
    regAddr_t    srcRs, srcRt, rtIdx, destEx;
    logic        isJr, aluFn, isLoad, isStore, isBranch, isJump, isLogicImm;
    logic        hazRt, loadEx, loadMem, expStall, taken, expPcSel, expWrite;
    aluSrc1_t    expAlu1;
    word_t       expRs, expRt, signImm, expImm, expTarget;
    logic [13:0] expCtrl;
    op = instruction[31:26];
    fn = instruction[5:0];
    srcRt = instruction[20:16];
    isJr = (op == OP_RTYPE) && (fn == FN_JR);
    aluFn = (op == OP_RTYPE) && (fn inside {FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT, FN_SLL});
    isLoad = op inside {OP_LW, OP_LH, OP_LB};
    isStore = op inside {OP_SW, OP_SH, OP_SB};
    isBranch = op inside {OP_BEQ, OP_BNE};
    isJump = op inside {OP_J, OP_JAL};
    isLogicImm = op inside {OP_ANDI, OP_ORI};
    // Only ALU ops, stores and branches read rt
    hazRt = aluFn || isStore || isBranch;
    // Operand reads, jr through ra, unused rt reads r0
    srcRs = isJr ? REG_RA : instruction[25:21];
    rtIdx = hazRt ? srcRt : 5'd0;
    expRs = (srcRs == 5'd0) ? '0 : model[srcRs];
    expRt = (rtIdx == 5'd0) ? '0 : model[rtIdx];
    if (isLogicImm)
      expAlu1 = ALU1_ZEROIMM;
    else if (op == OP_ADDI || isLoad || isStore)
      expAlu1 = ALU1_SIGNIMM;
    else
      expAlu1 = ALU1_REG;
    expWrite = aluFn || isLoad || (op == OP_ADDI) || isLogicImm;
    // Hazards
    loadEx = opcodeEx inside {OP_LW, OP_LH, OP_LB};
    loadMem = opcodeMem inside {OP_LW, OP_LH, OP_LB};
    destEx = (opcodeEx == OP_RTYPE) ? rdEx : rtEx;
    expStall = (loadEx && (rtEx != 5'd0) &&
                ((rtEx == srcRs) || (hazRt && (rtEx == srcRt)))) ||
               ((isBranch || isJr) && (pendingAt(srcRs, destEx, loadMem) ||
                                       (hazRt && pendingAt(srcRt, destEx, loadMem))));
    // Redirect
    if (op == OP_BEQ)
      taken = (expRs == expRt);
    else if (op == OP_BNE)
      taken = (expRs != expRt);
    else
      taken = isJump || isJr;
    expPcSel = taken && !expStall;
    signImm = {{16{instruction[15]}}, instruction[15:0]};
    expImm = isLogicImm ? {16'h0000, instruction[15:0]} : signImm;
    if (isJump)
      expTarget = {pcPlusFour[31:28], instruction[25:0], 2'b00};
    else if (isJr)
      expTarget = expRs;
    else
      expTarget = pcPlusFour + (signImm << 2);
    expCtrl = {expWrite, isLoad, isLoad, isStore,
               isLoad ? widthOf(op) : WIDTH_WORD, isStore ? widthOf(op) : WIDTH_WORD,
               aluFn, (op == OP_RTYPE) && (fn == FN_SLL), expAlu1, expPcSel, expStall};
    checkCtrl("control", expCtrl, {regWriteOut, memToReg, rEnable, wEnable, rWidth, wWidth,
                                   regDst, aluSrc0, aluSrc1, pcSel, stallPc});
    checkWord("regData1", expRs, regData1);
    checkWord("regData2", expRt, regData2);
    checkWord("v0", model[REG_V0], v0);
    checkWord("v1", model[REG_V1], v1);
    checkWord("imm32", expImm, imm32);
    if (isBranch || isJump || isJr) begin
      checkWord("branchPc", expTarget, branchPc);
    end
    checkStall("stallPc", expStall, stallPc);
    checkStall("stallId", expStall, stallId);
    checkStall("bubbleIdEx", expStall, bubbleIdEx);
    checkStall("pcSelWhileStalled", 1'b0, pcSel && stallPc);
  endtask

  // Mirror of the clock-edge writes, jal last so it wins on ra
  task automatic updateModel();
    if (regWrite && (rDestSelectedId != 5'd0)) begin
      model[rDestSelectedId] = regWriteData;
    end
    if (instruction[31:26] == OP_JAL) begin
      model[REG_RA] = pcPlusFour;
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // Low registers half the time so hazards hit often
  function automatic regAddr_t pickReg();
    return ($urandom % 2 == 0) ? 5'($urandom % 8) : 5'($urandom);
  endfunction

  function automatic opcode_t pickOpcode();
    case ($urandom % 6)
      0:       return OP_LW;
      1:       return OP_LH;
      2:       return OP_LB;
      3:       return OP_RTYPE;
      4:       return OP_ADDI;
      default: return 6'($urandom);
    endcase
  endfunction

  function automatic word_t randomInstruction();
    opcode_t  op;
    funct_t   fn;
    regAddr_t rs;
    regAddr_t rt;
    int       kind;
    kind = $urandom % 22;
    rs = pickReg();
    rt = pickReg();
    op = OP_RTYPE;
    fn = 6'($urandom);
    case (kind)
      0:  fn = FN_ADD;
      1:  fn = FN_SUB;
      2:  fn = FN_AND;
      3:  fn = FN_OR;
      4:  fn = FN_SLT;
      5:  fn = FN_SLL;
      6:  fn = FN_JR;
      7:  op = OP_ADDI;
      8:  op = OP_ANDI;
      9:  op = OP_ORI;
      10: op = OP_LW;
      11: op = OP_LH;
      12: op = OP_LB;
      13: op = OP_SW;
      14: op = OP_SH;
      15: op = OP_SB;
      16: op = OP_BEQ;
      17: op = OP_BNE;
      18: op = OP_J;
      19: op = OP_JAL;
      // Mostly unknown opcodes
      20: op = 6'($urandom);
      // Kind 21 keeps R-type with a random funct
      default: ;
    endcase
    // Equal operands so branches are taken often enough
    if ((op == OP_BEQ || op == OP_BNE) && ($urandom % 3 == 0)) begin
      rt = rs;
    end
    return {op, rs, rt, 10'($urandom), fn};
  endfunction

  // Plain add reads every register on both ports
  task automatic readBackAll();
    for (int r = 0; r < 32; r++) begin
      instruction = {OP_RTYPE, 5'(r), 5'(r), 5'd0, 5'd0, FN_ADD};
      regWrite = 1'b0;
      #(CLK_PERIOD / 4);
      checkOutputs();
      @(negedge Clock);
    end
  endtask

  initial begin
    void'($urandom(32509));
    rst = 1'b1;
    instruction = '0;
    pcPlusFour = '0;
    rDestSelectedId = '0;
    regWriteData = '0;
    regWrite = 1'b0;
    rtEx = '0;
    rdEx = '0;
    rDestSelectedMem = '0;
    opcodeEx = OP_RTYPE;
    opcodeMem = OP_RTYPE;
    cycle = -1;
    for (int i = 0; i < 32; i++) begin
      model[i] = '0;
    end
    repeat (2) @(posedge Clock);
    @(negedge Clock);
    rst = 1'b0;
    readBackAll();
    for (cycle = 0; cycle < NUM_CYCLES; cycle++) begin
      // Inputs change on the falling edge, checked mid low phase
      instruction = randomInstruction();
      pcPlusFour = {30'($urandom), 2'b00};
      regWrite = 1'($urandom);
      rDestSelectedId = pickReg();
      regWriteData = $urandom;
      rtEx = pickReg();
      rdEx = pickReg();
      rDestSelectedMem = pickReg();
      opcodeEx = pickOpcode();
      opcodeMem = pickOpcode();
      #(CLK_PERIOD / 4);
      checkOutputs();
      updateModel();
      @(negedge Clock);
    end
    cycle = NUM_CYCLES;
    readBackAll();
    $display("Test passed");
    $finish;
  end

  //////////////////////////////////////////////////
  // Watchdog
  //////////////////////////////////////////////////

  initial begin
    #(NUM_CYCLES * CLK_PERIOD * 2 + RESET_TIME);
    $display("Test failed");
    $fatal(1, "Watchdog timeout, stimulus did not complete");
  end

endmodule

//--- build.f
common/isaPkg.sv
common/controlPkg.sv
common/regReadIf.sv
instructionDecode/decodeController.sv
instructionDecode/registerFile.sv
instructionDecode/immediateBranchUnit.sv
instructionDecode/hazardDetector.sv
instructionDecode/instructionDecode.sv
verification/instructionDecodeTb.sv

//--- run.sh
#!/bin/sh
# Compile with Verilator and run; the exit status carries pass or fail
verilator --binary --timing -f build.f --top-module instructionDecodeTb \
  -Mdir obj_dir -o simv &&
  ./obj_dir/simv ||
  exit 1
